// File: Makefile
TOP = arcade_video_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) \
		-Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > run.log 2>&1; cat run.log
	grep -qx "TEST OK" run.log

clean:
	rm -rf obj_dir run.log

// File: compile.f
hdl/video_pkg.sv
hdl/load_pkg.sv
hdl/clk_enables.sv
hdl/video_timing.sv
hdl/rom_loader.sv
hdl/word_mem.sv
hdl/tile_render.sv
hdl/arcade_video_top.sv
testbench/arcade_video_tb.sv

// File: hdl/arcade_video_top.sv
`timescale 1ns/10ps

module arcade_video_top #(
    parameter int CLK_SPEED = 48,
    parameter int H_ACTIVE  = video_pkg::H_ACTIVE_DEF,
    parameter int H_TOTAL   = video_pkg::H_TOTAL_DEF,
    parameter int V_ACTIVE  = video_pkg::V_ACTIVE_DEF,
    parameter int V_TOTAL   = video_pkg::V_TOTAL_DEF
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              downloading,
    input  logic [load_pkg::IOCTL_AW-1:0]     ioctl_addr,
    input  logic [7:0]                        ioctl_data,
    input  logic                              ioctl_wr,
    output logic [video_pkg::COLOR_W-1:0]     red,
    output logic [video_pkg::COLOR_W-1:0]     green,
    output logic [video_pkg::COLOR_W-1:0]     blue,
    output logic                              hs,
    output logic                              vs,
    output logic                              lhbl,
    output logic                              lvbl,
    output logic                              pxl_cen,
    output logic [video_pkg::FRAME_CNT_W-1:0] frame_cnt
);

    logic [$clog2(H_TOTAL)-1:0]               hcnt;
    logic [$clog2(V_TOTAL)-1:0]               vcnt;
    logic                                     hblank;
    logic                                     vblank;
    logic                                     raw_hs;
    logic                                     raw_vs;
    logic                                     tile_we;
    logic [$clog2(load_pkg::TILE_WORDS)-1:0]  tile_waddr;
    load_pkg::tile_word_t                     tile_wdata;
    logic [$clog2(load_pkg::TILE_WORDS)-1:0]  tile_raddr;
    load_pkg::tile_word_t                     tile_rdata;
    logic                                     pal_we;
    logic [$clog2(load_pkg::PAL_ENTRIES)-1:0] pal_waddr;
    video_pkg::pal_color_t                    pal_wdata;
    logic [$clog2(load_pkg::PAL_ENTRIES)-1:0] pal_raddr;
    video_pkg::pal_color_t                    pal_rdata;

    // only the 6 MHz strobe drives the video
    clk_enables #(.CLK_SPEED(CLK_SPEED)) cen_i (
        .clk    ( clk     ),
        .reset  ( reset   ),
        .cen12  (         ),
        .cen6   ( pxl_cen ),
        .cen3   (         ),
        .cen1p5 (         )
    );

    video_timing #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) timing_i (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen6      ( pxl_cen   ),
        .hcnt      ( hcnt      ),
        .vcnt      ( vcnt      ),
        .hblank    ( hblank    ),
        .vblank    ( vblank    ),
        .hs        ( raw_hs    ),
        .vs        ( raw_vs    ),
        .frame_cnt ( frame_cnt )
    );

    rom_loader loader_i (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .tile_we     ( tile_we     ),
        .tile_waddr  ( tile_waddr  ),
        .tile_wdata  ( tile_wdata  ),
        .pal_we      ( pal_we      ),
        .pal_waddr   ( pal_waddr   ),
        .pal_wdata   ( pal_wdata   )
    );

    word_mem #(
        .word_t ( load_pkg::tile_word_t ),
        .DEPTH  ( load_pkg::TILE_WORDS  )
    ) tile_mem_i (
        .clk   ( clk        ),
        .we    ( tile_we    ),
        .waddr ( tile_waddr ),
        .wdata ( tile_wdata ),
        .raddr ( tile_raddr ),
        .rdata ( tile_rdata )
    );

    word_mem #(
        .word_t ( video_pkg::pal_color_t ),
        .DEPTH  ( load_pkg::PAL_ENTRIES  )
    ) pal_mem_i (
        .clk   ( clk       ),
        .we    ( pal_we    ),
        .waddr ( pal_waddr ),
        .wdata ( pal_wdata ),
        .raddr ( pal_raddr ),
        .rdata ( pal_rdata )
    );

    tile_render #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) render_i (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .cen6        ( pxl_cen     ),
        .downloading ( downloading ),
        .hcnt        ( hcnt        ),
        .vcnt        ( vcnt        ),
        .hblank      ( hblank      ),
        .vblank      ( vblank      ),
        .hs_in       ( raw_hs      ),
        .vs_in       ( raw_vs      ),
        .tile_raddr  ( tile_raddr  ),
        .tile_rdata  ( tile_rdata  ),
        .pal_raddr   ( pal_raddr   ),
        .pal_rdata   ( pal_rdata   ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        ),
        .lhbl        ( lhbl        ),
        .lvbl        ( lvbl        ),
        .hs          ( hs          ),
        .vs          ( vs          )
    );

endmodule

// File: hdl/clk_enables.sv
`timescale 1ns/10ps

module clk_enables #(
    parameter int CLK_SPEED = 48
) (
    input  logic clk,
    input  logic reset,
    output logic cen12,
    output logic cen6,
    output logic cen3,
    output logic cen1p5
);

    // clocks per 12 MHz strobe, 4 at 48 MHz and 2 at 24 MHz
    localparam int DIV = CLK_SPEED / 12;
    localparam int W12 = $clog2(DIV);
    localparam int CW  = W12 + 3;

    logic [CW-1:0] cnt;

    // one shared counter keeps all strobes phase aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt    <= '0;
            cen12  <= 1'b0;
            cen6   <= 1'b0;
            cen3   <= 1'b0;
            cen1p5 <= 1'b0;
        end else begin
            cnt    <= cnt + 1'b1;
            cen12  <= cnt[W12-1:0] == '0;
            cen6   <= cnt[W12:0] == '0;
            cen3   <= cnt[W12+1:0] == '0;
            cen1p5 <= cnt == '0;
        end
    end

    // pixel strobe must land on a 12 MHz strobe
    a_cen6_on_cen12: assert property (
        @(posedge clk) disable iff (reset) cen6 |-> cen12
    ) else $error("cen6 without cen12");

endmodule

// File: hdl/load_pkg.sv
package load_pkg;

    // ioctl byte address width
    localparam int IOCTL_AW = 22;

    // four colour indices per word, [0] is the leftmost pixel
    typedef logic [3:0][3:0] tile_word_t;

    localparam int TILE_WORDS = 2048;

    // byte address map, tiles below PAL_BASE
    localparam int PAL_BASE    = 4096;
    localparam int PAL_ENTRIES = 16;

endpackage

// File: hdl/rom_loader.sv
`timescale 1ns/10ps

module rom_loader (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      downloading,
    input  logic [load_pkg::IOCTL_AW-1:0]             ioctl_addr,
    input  logic [7:0]                                ioctl_data,
    input  logic                                      ioctl_wr,
    output logic                                      tile_we,
    output logic [$clog2(load_pkg::TILE_WORDS)-1:0]   tile_waddr,
    output load_pkg::tile_word_t                      tile_wdata,
    output logic                                      pal_we,
    output logic [$clog2(load_pkg::PAL_ENTRIES)-1:0]  pal_waddr,
    output video_pkg::pal_color_t                     pal_wdata
);

    localparam int TAW     = $clog2(load_pkg::TILE_WORDS);
    localparam int PAW     = $clog2(load_pkg::PAL_ENTRIES);
    localparam int PAL_END = load_pkg::PAL_BASE + 2 * load_pkg::PAL_ENTRIES;

    logic [7:0]                    low_byte;
    logic                          byte_wr;
    logic                          in_tile;
    logic                          in_pal;
    logic [load_pkg::IOCTL_AW-1:0] pal_offset;

    assign byte_wr    = ioctl_wr && downloading;
    assign in_tile    = int'(ioctl_addr) < load_pkg::PAL_BASE;
    assign in_pal     = !in_tile && (int'(ioctl_addr) < PAL_END);
    assign pal_offset = ioctl_addr - load_pkg::IOCTL_AW'(load_pkg::PAL_BASE);

    // even byte waits for its odd partner
    always_ff @(posedge clk) begin
        if (byte_wr && !ioctl_addr[0]) begin
            low_byte <= ioctl_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tile_we <= 1'b0;
            pal_we  <= 1'b0;
        end else begin
            tile_we <= byte_wr && ioctl_addr[0] && in_tile;
            pal_we  <= byte_wr && ioctl_addr[0] && in_pal;
        end
    end

    // word address is the byte address halved
    always_ff @(posedge clk) begin
        tile_waddr <= ioctl_addr[TAW:1];
        tile_wdata <= {ioctl_data, low_byte};
        pal_waddr  <= pal_offset[PAW:1];
        pal_wdata  <= video_pkg::pal_color_t'({ioctl_data[3:0], low_byte});
    end

    a_one_target: assert property (
        @(posedge clk) disable iff (reset) !(tile_we && pal_we)
    ) else $error("tile and palette written together");

endmodule

// File: hdl/tile_render.sv
`timescale 1ns/10ps

module tile_render #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEF,
    parameter int H_TOTAL  = video_pkg::H_TOTAL_DEF,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE_DEF,
    parameter int V_TOTAL  = video_pkg::V_TOTAL_DEF
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      cen6,
    input  logic                                      downloading,
    input  logic [$clog2(H_TOTAL)-1:0]                hcnt,
    input  logic [$clog2(V_TOTAL)-1:0]                vcnt,
    input  logic                                      hblank,
    input  logic                                      vblank,
    input  logic                                      hs_in,
    input  logic                                      vs_in,
    output logic [$clog2(load_pkg::TILE_WORDS)-1:0]   tile_raddr,
    input  load_pkg::tile_word_t                      tile_rdata,
    output logic [$clog2(load_pkg::PAL_ENTRIES)-1:0]  pal_raddr,
    input  video_pkg::pal_color_t                     pal_rdata,
    output logic [video_pkg::COLOR_W-1:0]             red,
    output logic [video_pkg::COLOR_W-1:0]             green,
    output logic [video_pkg::COLOR_W-1:0]             blue,
    output logic                                      lhbl,
    output logic                                      lvbl,
    output logic                                      hs,
    output logic                                      vs
);

    localparam int HW  = $clog2(H_TOTAL);
    localparam int VW  = $clog2(V_TOTAL);
    localparam int TAW = $clog2(load_pkg::TILE_WORDS);

    logic [VW-1:0]                 row;
    logic [HW-3:0]                 col;
    logic [3:0]                    s1_idx;
    logic                          s1_hblank;
    logic                          s1_vblank;
    logic                          s1_hs;
    logic                          s1_vs;
    video_pkg::pal_color_t         pix;

    // reads stay inside the visible tile area
    assign row        = (int'(vcnt) < V_ACTIVE) ? vcnt : '0;
    assign col        = (int'(hcnt) < H_ACTIVE) ? hcnt[HW-1:2] : '0;
    assign tile_raddr = TAW'(row * (H_ACTIVE / 4)) + TAW'(col);

    // stage 1, pick the nibble of the fetched word
    always_ff @(posedge clk) begin
        if (cen6) begin
            s1_idx <= tile_rdata[hcnt[1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_hblank <= 1'b1;
            s1_vblank <= 1'b1;
            s1_hs     <= 1'b0;
            s1_vs     <= 1'b0;
        end else if (cen6) begin
            s1_hblank <= hblank;
            s1_vblank <= vblank;
            s1_hs     <= hs_in;
            s1_vs     <= vs_in;
        end
    end

    assign pal_raddr = s1_idx;

    // stage 2, colour and timing leave together
    always_ff @(posedge clk) begin
        if (reset) begin
            pix  <= '0;
            lhbl <= 1'b0;
            lvbl <= 1'b0;
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else if (cen6) begin
            pix  <= (s1_hblank || s1_vblank) ? '0 : pal_rdata;
            lhbl <= !s1_hblank;
            lvbl <= !s1_vblank;
            hs   <= s1_hs;
            vs   <= s1_vs;
        end
    end

    // black while memories are being loaded
    assign red   = downloading ? '0 : pix.red;
    assign green = downloading ? '0 : pix.green;
    assign blue  = downloading ? '0 : pix.blue;

endmodule

// File: hdl/video_pkg.sv
package video_pkg;

    // raster defaults, pixels per line and lines per frame
    localparam int H_ACTIVE_DEF = 32;
    localparam int H_TOTAL_DEF  = 48;
    localparam int V_ACTIVE_DEF = 16;
    localparam int V_TOTAL_DEF  = 24;

    // sync pulses, placed relative to the end of the active area
    localparam int HS_START_DEF = 4;
    localparam int HS_LEN_DEF   = 4;
    localparam int VS_START_DEF = 2;
    localparam int VS_LEN_DEF   = 2;

    localparam int COLOR_W     = 4;
    localparam int FRAME_CNT_W = 32;

    // red sits in the high nibble
    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } pal_color_t;

endpackage

// File: hdl/video_timing.sv
`timescale 1ns/10ps

module video_timing #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEF,
    parameter int H_TOTAL  = video_pkg::H_TOTAL_DEF,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE_DEF,
    parameter int V_TOTAL  = video_pkg::V_TOTAL_DEF
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cen6,
    output logic [$clog2(H_TOTAL)-1:0]        hcnt,
    output logic [$clog2(V_TOTAL)-1:0]        vcnt,
    output logic                              hblank,
    output logic                              vblank,
    output logic                              hs,
    output logic                              vs,
    output logic [video_pkg::FRAME_CNT_W-1:0] frame_cnt
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    // sync windows inside the blanking interval
    localparam int HS_BEGIN = H_ACTIVE + video_pkg::HS_START_DEF;
    localparam int HS_END   = HS_BEGIN + video_pkg::HS_LEN_DEF;
    localparam int VS_BEGIN = V_ACTIVE + video_pkg::VS_START_DEF;
    localparam int VS_END   = VS_BEGIN + video_pkg::VS_LEN_DEF;

    logic h_last;
    logic v_last;

    assign h_last = hcnt == HW'(H_TOTAL - 1);
    assign v_last = vcnt == VW'(V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            hcnt      <= '0;
            vcnt      <= '0;
            frame_cnt <= '0;
        end else if (cen6) begin
            if (h_last) begin
                hcnt <= '0;
                if (v_last) begin
                    vcnt      <= '0;
                    // counts on the wrap of the last pixel
                    frame_cnt <= frame_cnt + 1'b1;
                end else begin
                    vcnt <= vcnt + 1'b1;
                end
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    // flags decoded straight from the counters
    assign hblank = int'(hcnt) >= H_ACTIVE;
    assign vblank = int'(vcnt) >= V_ACTIVE;
    assign hs     = (int'(hcnt) >= HS_BEGIN) && (int'(hcnt) < HS_END);
    assign vs     = (int'(vcnt) >= VS_BEGIN) && (int'(vcnt) < VS_END);

    a_hcnt_range: assert property (
        @(posedge clk) disable iff (reset) int'(hcnt) < H_TOTAL
    ) else $error("hcnt reached %0d", hcnt);

endmodule

// File: hdl/word_mem.sv
`timescale 1ns/10ps

module word_mem #(
    parameter type word_t = logic [15:0],
    parameter int  DEPTH  = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output word_t                    rdata
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // one cycle read latency, old data on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: testbench/arcade_video_tb.sv
`timescale 1ns/10ps

module arcade_video_tb;

    localparam int CLK_SPEED  = 48;
    localparam int H_ACTIVE   = video_pkg::H_ACTIVE_DEF;
    localparam int H_TOTAL    = video_pkg::H_TOTAL_DEF;
    localparam int V_ACTIVE   = video_pkg::V_ACTIVE_DEF;
    localparam int V_TOTAL    = video_pkg::V_TOTAL_DEF;
    localparam int CEN_DIV    = CLK_SPEED / 6;
    localparam int TILE_AREA  = H_ACTIVE * V_ACTIVE / 4;
    localparam int WAIT_LIMIT = 2 * H_TOTAL * V_TOTAL * CEN_DIV;
    localparam int HS_BEGIN   = H_ACTIVE + video_pkg::HS_START_DEF;
    localparam int HS_END     = HS_BEGIN + video_pkg::HS_LEN_DEF;

    // {red, green, blue}, row 1 is the reload palette
    localparam logic [11:0] PAL_TABLE [2][16] = '{
        '{12'h000, 12'hf00, 12'h0f0, 12'h00f, 12'hff0, 12'h0ff, 12'hf0f, 12'hfff,
          12'h888, 12'h400, 12'h040, 12'h004, 12'h123, 12'h456, 12'h789, 12'habc},
        '{12'hfed, 12'hcba, 12'h987, 12'h654, 12'h321, 12'h0f8, 12'h8f0, 12'h08f,
          12'hf80, 12'h80f, 12'h5a5, 12'ha5a, 12'h3c3, 12'hc3c, 12'h777, 12'h111}
    };

    logic                              clk;
    logic                              reset;
    logic                              downloading;
    logic [load_pkg::IOCTL_AW-1:0]     ioctl_addr;
    logic [7:0]                        ioctl_data;
    logic                              ioctl_wr;
    logic [video_pkg::COLOR_W-1:0]     red;
    logic [video_pkg::COLOR_W-1:0]     green;
    logic [video_pkg::COLOR_W-1:0]     blue;
    logic                              hs;
    logic                              vs;
    logic                              lhbl;
    logic                              lvbl;
    logic                              pxl_cen;
    logic [video_pkg::FRAME_CNT_W-1:0] frame_cnt;

    logic [15:0] tile_model [TILE_AREA];
    int          err_mismatch;
    int          err_other;
    int          since_cen;
    logic        cen_seen;
    logic        timed_out;

    arcade_video_top #(
        .CLK_SPEED ( CLK_SPEED ),
        .H_ACTIVE  ( H_ACTIVE  ),
        .H_TOTAL   ( H_TOTAL   ),
        .V_ACTIVE  ( V_ACTIVE  ),
        .V_TOTAL   ( V_TOTAL   )
    ) dut_i (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .lhbl        ( lhbl        ),
        .lvbl        ( lvbl        ),
        .pxl_cen     ( pxl_cen     ),
        .frame_cnt   ( frame_cnt   )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            err_mismatch++;
            $display("MISMATCH %s: got %h expected %h", name, got, want);
        end
    endtask

    // one clock, sampled at the falling edge
    task automatic step_clock();
        @(negedge clk);
        if (!reset) begin
            since_cen++;
            if (pxl_cen) begin
                if (cen_seen) begin
                    assert (since_cen == CEN_DIV) else begin
                        err_other++;
                        $display("pixel enable came after %0d clocks, not %0d",
                                 since_cen, CEN_DIV);
                    end
                end
                cen_seen  = 1'b1;
                since_cen = 0;
            end
        end
        if (downloading) begin
            check_value("red", 32'(red), 32'h0);
            check_value("green", 32'(green), 32'h0);
            check_value("blue", 32'(blue), 32'h0);
        end
    endtask

    task automatic wait_vs(input logic level);
        int n;
        n = 0;
        while (vs !== level && n < WAIT_LIMIT) begin
            step_clock();
            n++;
        end
        assert (vs === level) else begin
            err_other++;
            timed_out = 1'b1;
            $display("timed out waiting for vs to become %0d", level);
        end
    endtask

    // one ioctl byte, strobes three clocks apart
    task automatic write_byte(input int addr, input logic [7:0] data);
        ioctl_addr = load_pkg::IOCTL_AW'(addr);
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        step_clock();
        ioctl_wr   = 1'b0;
        step_clock();
        step_clock();
    endtask

    task automatic load_tiles();
        for (int w = 0; w < TILE_AREA; w++) begin
            write_byte(2 * w, tile_model[w][7:0]);
            write_byte(2 * w + 1, tile_model[w][15:8]);
        end
    endtask

    task automatic load_palette(input int sel);
        for (int i = 0; i < load_pkg::PAL_ENTRIES; i++) begin
            write_byte(load_pkg::PAL_BASE + 2 * i, PAL_TABLE[sel][i][7:0]);
            write_byte(load_pkg::PAL_BASE + 2 * i + 1, {4'h0, PAL_TABLE[sel][i][11:8]});
        end
    endtask

    task automatic check_frames(input int frames, input int sel);
        int          n;
        int          lines;
        int          line_px;
        int          steps;
        int          col;
        int          hpos;
        logic        last_lhbl;
        logic [31:0] prev_fc;
        logic [15:0] word;
        logic [3:0]  idx;
        logic [11:0] want;
        // a load may end inside a vs pulse, whose end then opens the frame
        wait_vs(1'b1);
        if (timed_out) return;
        prev_fc = frame_cnt;
        for (int f = 0; f < frames; f++) begin
            wait_vs(1'b0);
            if (timed_out) return;
            n         = 0;
            lines     = 0;
            line_px   = 0;
            steps     = 0;
            hpos      = -1;
            last_lhbl = 1'b1;
            while (vs !== 1'b1 && steps < WAIT_LIMIT) begin
                step_clock();
                steps++;
                if (pxl_cen) begin
                    // pixel position in the line, from the first active pixel
                    if (lhbl && !last_lhbl) begin
                        hpos = 0;
                    end else if (hpos >= 0) begin
                        hpos++;
                    end
                    last_lhbl = lhbl;
                    if (hpos >= 0) begin
                        check_value("hs", 32'(hs), 32'(hpos >= HS_BEGIN && hpos < HS_END));
                    end
                    if (!(lhbl && lvbl)) begin
                        check_value("red in blanking", 32'(red), 32'h0);
                        check_value("green in blanking", 32'(green), 32'h0);
                        check_value("blue in blanking", 32'(blue), 32'h0);
                    end
                end
                if (pxl_cen && lhbl && lvbl) begin
                    if (n < H_ACTIVE * V_ACTIVE) begin
                        col  = n % H_ACTIVE;
                        word = tile_model[(n / H_ACTIVE) * (H_ACTIVE / 4) + col / 4];
                        idx  = word[4 * (col % 4) +: 4];
                        want = PAL_TABLE[sel][idx];
                        check_value($sformatf("red at pixel %0d", n), 32'(red), 32'(want[11:8]));
                        check_value($sformatf("green at pixel %0d", n), 32'(green),
                                    32'(want[7:4]));
                        check_value($sformatf("blue at pixel %0d", n), 32'(blue), 32'(want[3:0]));
                    end
                    n++;
                    line_px++;
                end else if (pxl_cen && line_px != 0) begin
                    check_value("visible pixels per line", 32'(line_px), 32'(H_ACTIVE));
                    lines++;
                    line_px = 0;
                end
            end
            assert (vs === 1'b1) else begin
                err_other++;
                timed_out = 1'b1;
                $display("timed out waiting for the end of frame %0d", f);
                return;
            end
            check_value("visible lines", 32'(lines), 32'(V_ACTIVE));
            check_value("visible pixels", 32'(n), 32'(H_ACTIVE * V_ACTIVE));
            check_value("frame_cnt", frame_cnt, prev_fc + 32'd1);
            prev_fc = frame_cnt;
        end
    endtask

    initial begin
        reset        = 1'b1;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = '0;
        ioctl_wr     = 1'b0;
        err_mismatch = 0;
        err_other    = 0;
        since_cen    = 0;
        cen_seen     = 1'b0;
        timed_out    = 1'b0;
        void'($urandom(32'h15f9_f6db));
        for (int i = 0; i < TILE_AREA; i++) begin
            tile_model[i] = 16'($urandom);
        end
        repeat (10) step_clock();
        check_value("hs", 32'(hs), 32'h0);
        check_value("vs", 32'(vs), 32'h0);
        check_value("lhbl", 32'(lhbl), 32'h0);
        check_value("lvbl", 32'(lvbl), 32'h0);
        check_value("frame_cnt", frame_cnt, 32'h0);
        reset = 1'b0;

        downloading = 1'b1;
        load_tiles();
        load_palette(0);
        downloading = 1'b0;
        check_frames(3, 0);

        // palette swap on unchanged tiles
        if (!timed_out) begin
            downloading = 1'b1;
            load_palette(1);
            downloading = 1'b0;
            check_frames(1, 1);
        end

        $display("errors: %0d mismatches, %0d other failures", err_mismatch, err_other);
        if (err_mismatch == 0 && err_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
